// File: exec_cluster.f
+incdir+.
exec_cluster_pkg.sv
exec_alu.sv
exec_mult_stage.sv
exec_mult.sv
exec_branch.sv
exec_rollback_select.sv
exec_cluster.sv
exec_cluster_asserts.sv
exec_cluster_tb.sv

// File: Bender.yml
package:
  name: exec_cluster

sources:
  - include_dirs:
      - .
    files:
      - exec_cluster_pkg.sv
      - exec_alu.sv
      - exec_mult_stage.sv
      - exec_mult.sv
      - exec_branch.sv
      - exec_rollback_select.sv
      - exec_cluster.sv
  - target: test
    include_dirs:
      - .
    files:
      - exec_cluster_asserts.sv
      - exec_cluster_tb.sv

// File: exec_cluster_tb.sv
`default_nettype none

`include "exec_cluster_config.svh"

module exec_cluster_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int STAGES = `FU_MULT_STAGES;
  localparam int ROB    = `FU_NUM_ROB;
  // reset, alu, mult flow, mult stall, branches, two rollbacks, margin
  localparam int RUN_CYCLES =
    5 + 128 + (6 + STAGES) + (8 + 6 * STAGES) + 56 + 2 * (STAGES + 5) + 50;

  logic                         clock;
  logic                         reset;
  exec_cluster_pkg::fu_issue_t  issue_alu;
  exec_cluster_pkg::fu_issue_t  issue_mul;
  exec_cluster_pkg::fu_issue_t  issue_br0;
  exec_cluster_pkg::fu_issue_t  issue_br1;
  logic [3:0]                   bus_free;
  exec_cluster_pkg::rob_idx_t   rob_tail;
  exec_cluster_pkg::fu_result_t result_alu;
  exec_cluster_pkg::fu_result_t result_mul;
  exec_cluster_pkg::fu_result_t result_br0;
  exec_cluster_pkg::fu_result_t result_br1;
  logic [3:0]                   accept;
  exec_cluster_pkg::rollback_t  rollback;
  integer                       seed;

  exec_cluster i_dut (.*);

  always #10 clock = ~clock;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else begin
      abort_run($sformatf("Error: %s is %h, expected %h", name, got, exp));
    end
  endtask

  task automatic check_true(input logic ok, input string what);
    assert (ok === 1'b1) else begin
      abort_run(what);
    end
  endtask

  // tags ride along unchanged from issue to result
  task automatic check_tags(input string name, input exec_cluster_pkg::fu_result_t res,
                            input exec_cluster_pkg::fu_issue_t op);
    check_value({name, ".dest_idx"}, res.dest_idx, op.dest_idx);
    check_value({name, ".t_idx"}, res.t_idx, op.t_idx);
    check_value({name, ".rob_idx"}, res.rob_idx, op.rob_idx);
    check_value({name, ".fl_idx"}, res.fl_idx, op.fl_idx);
  endtask

  function automatic exec_cluster_pkg::word_t rand_word();
    return {$random(seed), $random(seed)};
  endfunction

  // random operands and tags, unit-specific fields set by the caller
  function automatic exec_cluster_pkg::fu_issue_t make_op(input exec_cluster_pkg::alu_func_e f,
                                                          input exec_cluster_pkg::opb_sel_e sel,
                                                          input int tag);
    exec_cluster_pkg::fu_issue_t op;
    op          = '0;
    op.ready    = 1'b1;
    op.func     = f;
    op.opb_sel  = sel;
    op.lit      = $random(seed);
    op.disp     = $random(seed);
    op.npc      = rand_word();
    op.t1_value = rand_word();
    op.t2_value = rand_word();
    op.dest_idx = $random(seed);
    op.t_idx    = $random(seed);
    op.fl_idx   = $random(seed);
    op.rob_idx  = exec_cluster_pkg::rob_idx_t'(tag);
    return op;
  endfunction

  // second operand, literal zero extended
  function automatic exec_cluster_pkg::word_t opb_of(input exec_cluster_pkg::fu_issue_t op);
    if (op.opb_sel == exec_cluster_pkg::OPB_IS_ALU_IMM) begin
      return 64'(op.lit);
    end
    return op.t2_value;
  endfunction

  function automatic exec_cluster_pkg::word_t ref_alu(input exec_cluster_pkg::alu_func_e f,
                                                      input exec_cluster_pkg::word_t a,
                                                      input exec_cluster_pkg::word_t b);
    case (f)
      exec_cluster_pkg::ALU_ADDQ:   return a + b;
      exec_cluster_pkg::ALU_SUBQ:   return a - b;
      exec_cluster_pkg::ALU_AND:    return a & b;
      exec_cluster_pkg::ALU_BIC:    return a & ~b;
      exec_cluster_pkg::ALU_BIS:    return a | b;
      exec_cluster_pkg::ALU_ORNOT:  return a | ~b;
      exec_cluster_pkg::ALU_XOR:    return a ^ b;
      exec_cluster_pkg::ALU_EQV:    return ~(a ^ b);
      exec_cluster_pkg::ALU_SRL:    return a >> b[5:0];
      exec_cluster_pkg::ALU_SLL:    return a << b[5:0];
      exec_cluster_pkg::ALU_SRA:    return $signed(a) >>> b[5:0];
      exec_cluster_pkg::ALU_CMPULT: return {63'd0, a < b};
      exec_cluster_pkg::ALU_CMPEQ:  return {63'd0, a == b};
      exec_cluster_pkg::ALU_CMPULE: return {63'd0, a <= b};
      exec_cluster_pkg::ALU_CMPLT:  return {63'd0, $signed(a) < $signed(b)};
      default:                      return {63'd0, $signed(a) <= $signed(b)};
    endcase
  endfunction

  function automatic logic ref_cond(input exec_cluster_pkg::br_cond_e c,
                                    input exec_cluster_pkg::word_t v);
    case (c)
      exec_cluster_pkg::BR_LBC: return !v[0];
      exec_cluster_pkg::BR_EQ:  return v == 0;
      exec_cluster_pkg::BR_LT:  return $signed(v) < 0;
      exec_cluster_pkg::BR_LE:  return $signed(v) <= 0;
      exec_cluster_pkg::BR_LBS: return v[0];
      exec_cluster_pkg::BR_NE:  return v != 0;
      exec_cluster_pkg::BR_GE:  return $signed(v) >= 0;
      default:                  return $signed(v) > 0;
    endcase
  endfunction

  // displacement counts words, register jump masks with not-three
  function automatic exec_cluster_pkg::word_t ref_target(input exec_cluster_pkg::fu_issue_t op);
    exec_cluster_pkg::word_t a;
    exec_cluster_pkg::word_t b;
    a = (op.opa_sel == exec_cluster_pkg::OPA_IS_NOT3) ? ~64'd3 : op.npc;
    b = (op.opb_sel == exec_cluster_pkg::OPB_IS_BR_DISP) ? 64'($signed(op.disp)) * 4
                                                         : op.t2_value;
    return (op.func == exec_cluster_pkg::ALU_AND) ? (a & b) : (a + b);
  endfunction

  // between rollback point and tail, counted around the ROB ring
  function automatic logic ref_squash(input int rb, input int tag, input int tail);
    return ((tag - rb + ROB) % ROB) <= ((tail - rb + ROB) % ROB);
  endfunction

  task automatic test_alu();
    exec_cluster_pkg::fu_issue_t op;
    for (int f = 0; f < 16; f++) begin
      for (int n = 0; n < 8; n++) begin
        op = make_op(exec_cluster_pkg::alu_func_e'(f),
                     n[0] ? exec_cluster_pkg::OPB_IS_ALU_IMM : exec_cluster_pkg::OPB_IS_REGB, n);
        // equal operands for the compares
        if (n == 2) begin
          op.t2_value = op.t1_value;
        end
        issue_alu   = op;
        // busy bus half the time, a ready op then waits
        bus_free[0] = n[2];
        #1;
        check_value("result_alu.result", result_alu.result,
                    ref_alu(op.func, op.t1_value, opb_of(op)));
        check_value("result_alu.done", result_alu.done, 1'b1);
        check_tags("result_alu", result_alu, op);
        check_value("accept[0]", accept[0], n[2]);
        @(posedge clock);
        #2;
      end
    end
    issue_alu   = '0;
    bus_free[0] = 1'b1;
  endtask

  task automatic test_mul_flow();
    exec_cluster_pkg::fu_issue_t ops [6];
    int j;
    for (int c = 0; c < 6 + STAGES; c++) begin
      issue_mul = '0;
      if (c < 6) begin
        ops[c] = make_op(exec_cluster_pkg::ALU_ADDQ,
                         (c == 3) ? exec_cluster_pkg::OPB_IS_ALU_IMM
                                  : exec_cluster_pkg::OPB_IS_REGB, c);
        issue_mul = ops[c];
      end
      @(posedge clock);
      #1;
      // issued in cycle j, visible after edge j + STAGES - 1
      j = c - STAGES + 1;
      if (j >= 0 && j < 6) begin
        check_value("result_mul.done", result_mul.done, 1'b1);
        check_tags("result_mul", result_mul, ops[j]);
        check_value("result_mul.result", result_mul.result,
                    ops[j].t1_value * opb_of(ops[j]));
      end else begin
        check_value("result_mul.done", result_mul.done, 1'b0);
      end
      #1;
    end
  endtask

  task automatic await_mul(input exec_cluster_pkg::fu_issue_t op);
    logic found;
    found = 1'b0;
    for (int w = 0; w < 2 * STAGES && !found; w++) begin
      @(posedge clock);
      #1;
      found = result_mul.done;
      #1;
    end
    check_true(found, "multiplier result did not appear in time");
    check_tags("result_mul", result_mul, op);
    check_value("result_mul.result", result_mul.result, op.t1_value * opb_of(op));
  endtask

  task automatic test_mul_stall();
    exec_cluster_pkg::fu_issue_t  ops [3];
    exec_cluster_pkg::fu_result_t held;
    for (int i = 0; i < 3; i++) begin
      ops[i]    = make_op(exec_cluster_pkg::ALU_ADDQ, exec_cluster_pkg::OPB_IS_REGB, 10 + i);
      issue_mul = ops[i];
      @(posedge clock);
      #2;
    end
    issue_mul = '0;
    await_mul(ops[0]);
    // bus busy, first result parked at the output
    bus_free[1] = 1'b0;
    held        = result_mul;
    // a ready op has to wait for the bus
    issue_mul   = make_op(exec_cluster_pkg::ALU_ADDQ, exec_cluster_pkg::OPB_IS_REGB, 20);
    repeat (5) begin
      @(posedge clock);
      #1;
      assert (result_mul === held) else begin
        abort_run($sformatf("Error: result_mul is %h, expected %h", result_mul, held));
      end
      check_value("accept[1]", accept[1], 1'b0);
      #1;
    end
    issue_mul   = '0;
    bus_free[1] = 1'b1;
    await_mul(ops[1]);
    await_mul(ops[2]);
  endtask

  task automatic test_branches();
    exec_cluster_pkg::fu_issue_t op;
    logic                        take;
    for (int n = 0; n < 56; n++) begin
      op = make_op(exec_cluster_pkg::ALU_ADDQ, exec_cluster_pkg::OPB_IS_BR_DISP, n);
      if (n < 48) begin
        op.cond        = exec_cluster_pkg::br_cond_e'(n / 6);
        op.cond_branch = 1'b1;
        // zero, odd, even, minus one, minus two, random
        case (n % 6)
          0: op.t1_value = '0;
          1: op.t1_value = 64'd1;
          2: op.t1_value = 64'd2;
          3: op.t1_value = '1;
          4: op.t1_value = ~64'd1;
          default: op.t1_value = rand_word();
        endcase
      end else begin
        // register jump
        op.opa_sel       = exec_cluster_pkg::OPA_IS_NOT3;
        op.opb_sel       = exec_cluster_pkg::OPB_IS_REGB;
        op.func          = exec_cluster_pkg::ALU_AND;
        op.uncond_branch = 1'b1;
      end
      take = op.uncond_branch || ref_cond(op.cond, op.t1_value);
      if (n[0]) begin
        issue_br1 = op;
      end else begin
        issue_br0 = op;
      end
      bus_free[2] = n[1];
      bus_free[3] = n[1];
      #1;
      check_value(n[0] ? "result_br1.result" : "result_br0.result",
                  n[0] ? result_br1.result : result_br0.result, ref_target(op));
      check_value(n[0] ? "result_br1.done" : "result_br0.done",
                  n[0] ? result_br1.done : result_br0.done, 1'b1);
      check_tags(n[0] ? "result_br1" : "result_br0", n[0] ? result_br1 : result_br0, op);
      check_value(n[0] ? "accept[3]" : "accept[2]", n[0] ? accept[3] : accept[2], n[1]);
      check_value("rollback.valid", rollback.valid, take);
      if (take) begin
        check_value("rollback.rob_idx", rollback.rob_idx, op.rob_idx);
        check_value("rollback.fl_idx", rollback.fl_idx, op.fl_idx);
        check_value("rollback.target", rollback.target, ref_target(op));
      end
      @(posedge clock);
      #2;
      issue_br0 = '0;
      issue_br1 = '0;
    end
    bus_free[3:2] = 2'b11;
  endtask

  task automatic test_rollback(input int tail, input int idx0, input int idx1);
    exec_cluster_pkg::fu_issue_t br0;
    exec_cluster_pkg::fu_issue_t br1;
    exec_cluster_pkg::fu_issue_t older;
    exec_cluster_pkg::fu_issue_t mul_old;
    exec_cluster_pkg::fu_issue_t mul_young;
    exec_cluster_pkg::fu_issue_t alu_op;
    logic                        seen;
    br0               = make_op(exec_cluster_pkg::ALU_ADDQ, exec_cluster_pkg::OPB_IS_BR_DISP, idx0);
    br1               = make_op(exec_cluster_pkg::ALU_ADDQ, exec_cluster_pkg::OPB_IS_BR_DISP, idx1);
    br0.uncond_branch = 1'b1;
    br1.uncond_branch = 1'b1;
    // farther back from the tail is older, a tie goes to br0
    older = ((tail - idx1 + ROB) % ROB > (tail - idx0 + ROB) % ROB) ? br1 : br0;
    mul_old   = make_op(exec_cluster_pkg::ALU_ADDQ, exec_cluster_pkg::OPB_IS_REGB,
                        (older.rob_idx + ROB - 1) % ROB);
    mul_young = make_op(exec_cluster_pkg::ALU_ADDQ, exec_cluster_pkg::OPB_IS_REGB,
                        (older.rob_idx + 1) % ROB);
    alu_op    = make_op(exec_cluster_pkg::ALU_XOR, exec_cluster_pkg::OPB_IS_REGB,
                        (older.rob_idx + 2) % ROB);
    rob_tail  = tail;
    issue_mul = mul_old;
    @(posedge clock);
    #2;
    issue_mul = mul_young;
    @(posedge clock);
    #2;
    // both branches redirect in the same cycle
    issue_mul   = '0;
    issue_br0   = br0;
    issue_br1   = br1;
    issue_alu   = alu_op;
    bus_free[0] = 1'b0;
    #1;
    check_value("rollback.valid", rollback.valid, 1'b1);
    check_value("rollback.rob_idx", rollback.rob_idx, older.rob_idx);
    check_value("rollback.fl_idx", rollback.fl_idx, older.fl_idx);
    check_value("rollback.target", rollback.target, ref_target(older));
    check_value("result_alu.done", result_alu.done,
                !ref_squash(older.rob_idx, alu_op.rob_idx, tail));
    check_value("accept[0]", accept[0], 1'b1);
    @(posedge clock);
    #2;
    issue_br0   = '0;
    issue_br1   = '0;
    issue_alu   = '0;
    bus_free[0] = 1'b1;
    seen        = 1'b0;
    // older multiply must drain, younger one never shows
    repeat (STAGES + 2) begin
      @(posedge clock);
      #1;
      if (result_mul.done) begin
        check_true(result_mul.rob_idx !== mul_young.rob_idx,
                   "a squashed multiply reached the result bus");
        check_value("result_mul.rob_idx", result_mul.rob_idx, mul_old.rob_idx);
        check_value("result_mul.result", result_mul.result,
                    mul_old.t1_value * opb_of(mul_old));
        seen = 1'b1;
      end
      #1;
    end
    check_true(seen, "the older multiply was lost at the rollback");
  endtask

  // bound checker counts its own failures
  always @(posedge clock) begin
    assert (i_dut.i_asserts.fail_count == 0) else begin
      abort_run("a concurrent assertion in the bound checker failed");
    end
  end

  initial begin
    #(RUN_CYCLES * 20);
    abort_run("watchdog timeout, the tests did not finish in time");
  end

  initial begin
    seed      = 32'hdad9;
    clock     = 1'b0;
    reset     = 1'b1;
    issue_alu = '0;
    issue_mul = '0;
    issue_br0 = '0;
    issue_br1 = '0;
    bus_free  = 4'hf;
    rob_tail  = '0;
    repeat (5) @(posedge clock);
    #2;
    reset = 1'b0;
    test_alu();
    test_mul_flow();
    test_mul_stall();
    test_branches();
    // br1 older, then br0 older across the ring wrap
    test_rollback(20, 12, 8);
    test_rollback(3, 30, 1);
    if (i_dut.i_asserts.fail_count == 0) begin
      $display("** PASS **");
      $finish;
    end else begin
      abort_run("a concurrent assertion in the bound checker failed");
    end
  end

endmodule

`default_nettype wire

// File: exec_cluster_asserts.sv
`default_nettype none

module exec_cluster_asserts (
  input logic                         clock,
  input logic                         reset,
  input exec_cluster_pkg::fu_issue_t  issue_alu,
  input exec_cluster_pkg::fu_issue_t  issue_mul,
  input exec_cluster_pkg::fu_issue_t  issue_br0,
  input exec_cluster_pkg::fu_issue_t  issue_br1,
  input exec_cluster_pkg::fu_result_t result_mul,
  input exec_cluster_pkg::fu_result_t result_br0,
  input exec_cluster_pkg::fu_result_t result_br1,
  input logic [3:0]                   accept,
  input exec_cluster_pkg::rollback_t  rollback
);
  timeunit 1ns;
  timeprecision 100ps;

  int unsigned fail_count = 0;

  // a rollback needs a finished branch behind it
  rollback_from_branch: assert property (@(posedge clock) disable iff (reset)
    rollback.valid |-> (result_br0.done || result_br1.done))
    else begin
      $error("rollback valid with no branch result done");
      fail_count++;
    end

  // pipe empty right after reset
  mult_empty_after_reset: assert property (@(posedge clock) reset |=> !result_mul.done)
    else begin
      $error("multiplier done high in the cycle after reset");
      fail_count++;
    end

  // idle unit always frees its slot
  idle_units_accept: assert property (@(posedge clock) disable iff (reset)
    (issue_alu.ready || accept[0]) && (issue_mul.ready || accept[1]) &&
    (issue_br0.ready || accept[2]) && (issue_br1.ready || accept[3]))
    else begin
      $error("accept low for a unit with no ready issue");
      fail_count++;
    end

endmodule

bind exec_cluster exec_cluster_asserts i_asserts (.*);

`default_nettype wire

// File: exec_cluster.sv
`default_nettype none

// bus_free and accept bits: 0 alu, 1 mul, 2 br0, 3 br1
module exec_cluster (
  input  logic                         clock,
  input  logic                         reset,
  input  exec_cluster_pkg::fu_issue_t  issue_alu,
  input  exec_cluster_pkg::fu_issue_t  issue_mul,
  input  exec_cluster_pkg::fu_issue_t  issue_br0,
  input  exec_cluster_pkg::fu_issue_t  issue_br1,
  input  logic [3:0]                   bus_free,
  input  exec_cluster_pkg::rob_idx_t   rob_tail,
  output exec_cluster_pkg::fu_result_t result_alu,
  output exec_cluster_pkg::fu_result_t result_mul,
  output exec_cluster_pkg::fu_result_t result_br0,
  output exec_cluster_pkg::fu_result_t result_br1,
  output logic [3:0]                   accept,
  output exec_cluster_pkg::rollback_t  rollback
);

  logic taken0;
  logic taken1;

  exec_alu i_alu (
    .issue    (issue_alu),
    .rollback (rollback),
    .rob_tail (rob_tail),
    .bus_free (bus_free[0]),
    .result   (result_alu),
    .accept   (accept[0])
  );

  exec_mult i_mult (
    .clock    (clock),
    .reset    (reset),
    .issue    (issue_mul),
    .rollback (rollback),
    .rob_tail (rob_tail),
    .bus_free (bus_free[1]),
    .result   (result_mul),
    .accept   (accept[1])
  );

  exec_branch i_br0 (
    .issue    (issue_br0),
    .bus_free (bus_free[2]),
    .result   (result_br0),
    .accept   (accept[2]),
    .taken    (taken0)
  );

  exec_branch i_br1 (
    .issue    (issue_br1),
    .bus_free (bus_free[3]),
    .result   (result_br1),
    .accept   (accept[3]),
    .taken    (taken1)
  );

  // same-cycle rollback, feeds back into alu and mult squash
  exec_rollback_select i_rollback (
    .br0      (result_br0),
    .br1      (result_br1),
    .taken0   (taken0),
    .taken1   (taken1),
    .rob_tail (rob_tail),
    .rollback (rollback)
  );

endmodule

`default_nettype wire

// File: exec_rollback_select.sv
`default_nettype none

module exec_rollback_select (
  input  exec_cluster_pkg::fu_result_t br0,
  input  exec_cluster_pkg::fu_result_t br1,
  input  logic                         taken0,
  input  logic                         taken1,
  input  exec_cluster_pkg::rob_idx_t   rob_tail,
  output exec_cluster_pkg::rollback_t  rollback
);

  exec_cluster_pkg::rob_idx_t dist0;
  exec_cluster_pkg::rob_idx_t dist1;
  logic                       pick0;

  // distance back from the tail, larger means older
  assign dist0 = rob_tail - br0.rob_idx;
  assign dist1 = rob_tail - br1.rob_idx;

  // br1 wins only alone or when strictly older
  assign pick0 = taken0 && (!taken1 || (dist0 >= dist1));

  always_comb begin
    rollback.valid = taken0 || taken1;
    if (pick0) begin
      rollback.rob_idx = br0.rob_idx;
      rollback.fl_idx  = br0.fl_idx;
      rollback.target  = br0.result;
    end else if (taken1) begin
      rollback.rob_idx = br1.rob_idx;
      rollback.fl_idx  = br1.fl_idx;
      rollback.target  = br1.result;
    end else begin
      rollback.rob_idx = '0;
      rollback.fl_idx  = '0;
      rollback.target  = '0;
    end
  end

endmodule

`default_nettype wire

// File: exec_branch.sv
`default_nettype none

`include "exec_cluster_config.svh"

module exec_branch (
  input  exec_cluster_pkg::fu_issue_t  issue,
  input  logic                         bus_free,
  output exec_cluster_pkg::fu_result_t result,
  output logic                         accept,
  output logic                         taken
);

  exec_cluster_pkg::word_t opa;
  exec_cluster_pkg::word_t opb;
  exec_cluster_pkg::word_t t1;
  logic                    cond_true;

  assign t1     = issue.t1_value;
  assign accept = bus_free || !issue.ready;
  // idle unit never redirects
  assign taken  = issue.ready && (issue.uncond_branch || (issue.cond_branch && cond_true));

  // base test from low two bits, top bit inverts
  always_comb begin
    cond_true = 1'b0;
    if (issue.ready) begin
      case (issue.cond[1:0])
        2'b00: cond_true = !t1[0];
        2'b01: cond_true = (t1 == '0);
        2'b10: cond_true = t1[`FU_XLEN-1];
        2'b11: cond_true = t1[`FU_XLEN-1] || (t1 == '0);
        default: cond_true = 1'b0;
      endcase
      if (issue.cond[2]) begin
        cond_true = !cond_true;
      end
    end
  end

  // not-three clears the low bits of a register jump
  always_comb begin
    case (issue.opa_sel)
      exec_cluster_pkg::OPA_IS_NOT3: opa = ~exec_cluster_pkg::word_t'(3);
      default:                       opa = issue.npc;
    endcase
  end

  // displacement in words, sign extend and scale to bytes
  always_comb begin
    case (issue.opb_sel)
      exec_cluster_pkg::OPB_IS_BR_DISP:
        opb = {{(`FU_XLEN-23){issue.disp[20]}}, issue.disp, 2'b00};
      default:
        opb = issue.t2_value;
    endcase
  end

  always_comb begin
    if (issue.func == exec_cluster_pkg::ALU_AND) begin
      result.result = opa & opb;
    end else begin
      result.result = opa + opb;
    end
    result.dest_idx = issue.dest_idx;
    result.t_idx    = issue.t_idx;
    result.rob_idx  = issue.rob_idx;
    result.fl_idx   = issue.fl_idx;
    result.done     = issue.ready;
  end

endmodule

`default_nettype wire

// File: exec_mult.sv
`default_nettype none

`include "exec_cluster_config.svh"

module exec_mult (
  input  logic                         clock,
  input  logic                         reset,
  input  exec_cluster_pkg::fu_issue_t  issue,
  input  exec_cluster_pkg::rollback_t  rollback,
  input  exec_cluster_pkg::rob_idx_t   rob_tail,
  input  logic                         bus_free,
  output exec_cluster_pkg::fu_result_t result,
  output logic                         accept
);

  exec_cluster_pkg::word_t                             opb;
  // chain[0] is the seed, chain[i+1] is the output of stage i
  exec_cluster_pkg::mult_stage_t [`FU_MULT_STAGES:0]  chain;

  // whole pipe moves only when the result bus can take the tail
  assign accept = bus_free || !issue.ready;

  always_comb begin
    case (issue.opb_sel)
      exec_cluster_pkg::OPB_IS_ALU_IMM: opb = exec_cluster_pkg::word_t'(issue.lit);
      default:                          opb = issue.t2_value;
    endcase
  end

  // zero partial product to start
  assign chain[0] = '{
    res: '{
      done:     issue.ready,
      result:   '0,
      dest_idx: issue.dest_idx,
      t_idx:    issue.t_idx,
      rob_idx:  issue.rob_idx,
      fl_idx:   issue.fl_idx
    },
    mplier: issue.t1_value,
    mcand:  opb
  };

  for (genvar i = 0; i < `FU_MULT_STAGES; i++) begin : g_stage
    exec_mult_stage i_stage (
      .clock     (clock),
      .reset     (reset),
      .advance   (bus_free),
      .rollback  (rollback),
      .rob_tail  (rob_tail),
      .stage_in  (chain[i]),
      .stage_out (chain[i+1])
    );
  end

  // last partial product is the low word of the full product
  assign result = chain[`FU_MULT_STAGES].res;

endmodule

`default_nettype wire

// File: exec_mult_stage.sv
`default_nettype none

`include "exec_cluster_config.svh"

module exec_mult_stage (
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          advance,
  input  exec_cluster_pkg::rollback_t   rollback,
  input  exec_cluster_pkg::rob_idx_t    rob_tail,
  input  exec_cluster_pkg::mult_stage_t stage_in,
  output exec_cluster_pkg::mult_stage_t stage_out
);

  // multiplier bits consumed per stage
  localparam int unsigned CHUNK = `FU_XLEN / `FU_MULT_STAGES;

  exec_cluster_pkg::word_t       partial;
  exec_cluster_pkg::mult_stage_t next_rec;
  logic                          squash_in;
  logic                          squash_held;

  // incoming op and the op parked here during a stall
  assign squash_in   = exec_cluster_pkg::is_squashed(rollback, stage_in.res.rob_idx, rob_tail);
  assign squash_held = exec_cluster_pkg::is_squashed(rollback, stage_out.res.rob_idx, rob_tail);

  // low chunk of multiplier times the full multiplicand
  // evaluated at full word width, high bits fall off
  assign partial = stage_in.mplier[CHUNK-1:0] * stage_in.mcand;

  always_comb begin
    next_rec              = stage_in;
    next_rec.res.result   = stage_in.res.result + partial;
    next_rec.res.done     = stage_in.res.done && !squash_in;
    // line up the next chunk for the following stage
    next_rec.mplier       = stage_in.mplier >> CHUNK;
    next_rec.mcand        = stage_in.mcand << CHUNK;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      stage_out.res.done <= 1'b0;
    end else if (advance) begin
      stage_out <= next_rec;
    end else if (squash_held) begin
      // stalled op that a rollback killed
      stage_out.res.done <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: exec_alu.sv
`default_nettype none

`include "exec_cluster_config.svh"

module exec_alu (
  input  exec_cluster_pkg::fu_issue_t  issue,
  input  exec_cluster_pkg::rollback_t  rollback,
  input  exec_cluster_pkg::rob_idx_t   rob_tail,
  input  logic                         bus_free,
  output exec_cluster_pkg::fu_result_t result,
  output logic                         accept
);

  exec_cluster_pkg::word_t      opa;
  exec_cluster_pkg::word_t      opb;
  logic [$clog2(`FU_XLEN)-1:0]  shamt;
  logic                         squashed;

  // same sign: plain compare works, else the negative one is smaller
  function automatic logic signed_lt(exec_cluster_pkg::word_t a, exec_cluster_pkg::word_t b);
    if (a[`FU_XLEN-1] == b[`FU_XLEN-1]) begin
      return a < b;
    end
    return a[`FU_XLEN-1];
  endfunction

  assign squashed = exec_cluster_pkg::is_squashed(rollback, issue.rob_idx, rob_tail);
  assign accept   = bus_free || !issue.ready || squashed;

  assign opa   = issue.t1_value;
  assign shamt = opb[$clog2(`FU_XLEN)-1:0];

  // literal is zero extended
  always_comb begin
    case (issue.opb_sel)
      exec_cluster_pkg::OPB_IS_ALU_IMM: opb = exec_cluster_pkg::word_t'(issue.lit);
      default:                          opb = issue.t2_value;
    endcase
  end

  always_comb begin
    case (issue.func)
      exec_cluster_pkg::ALU_ADDQ:   result.result = opa + opb;
      exec_cluster_pkg::ALU_SUBQ:   result.result = opa - opb;
      exec_cluster_pkg::ALU_AND:    result.result = opa & opb;
      exec_cluster_pkg::ALU_BIC:    result.result = opa & ~opb;
      exec_cluster_pkg::ALU_BIS:    result.result = opa | opb;
      exec_cluster_pkg::ALU_ORNOT:  result.result = opa | ~opb;
      exec_cluster_pkg::ALU_XOR:    result.result = opa ^ opb;
      exec_cluster_pkg::ALU_EQV:    result.result = opa ^ ~opb;
      exec_cluster_pkg::ALU_SRL:    result.result = opa >> shamt;
      exec_cluster_pkg::ALU_SLL:    result.result = opa << shamt;
      // fill vacated high bits with the sign
      exec_cluster_pkg::ALU_SRA:
        result.result = (opa >> shamt) |
                        ({`FU_XLEN{opa[`FU_XLEN-1]}} & ~({`FU_XLEN{1'b1}} >> shamt));
      exec_cluster_pkg::ALU_CMPULT: result.result = exec_cluster_pkg::word_t'(opa < opb);
      exec_cluster_pkg::ALU_CMPEQ:  result.result = exec_cluster_pkg::word_t'(opa == opb);
      exec_cluster_pkg::ALU_CMPULE: result.result = exec_cluster_pkg::word_t'(opa <= opb);
      exec_cluster_pkg::ALU_CMPLT:  result.result = exec_cluster_pkg::word_t'(signed_lt(opa, opb));
      exec_cluster_pkg::ALU_CMPLE:
        result.result = exec_cluster_pkg::word_t'(signed_lt(opa, opb) || (opa == opb));
      default:                      result.result = '0;
    endcase
    // tags pass straight through
    result.dest_idx = issue.dest_idx;
    result.t_idx    = issue.t_idx;
    result.rob_idx  = issue.rob_idx;
    result.fl_idx   = issue.fl_idx;
    // younger than a taken branch, drop it
    result.done     = issue.ready && !squashed;
  end

endmodule

`default_nettype wire

// File: exec_cluster_pkg.sv
`default_nettype none

`include "exec_cluster_config.svh"

package exec_cluster_pkg;

  // widths with a meaning
  typedef logic [`FU_XLEN-1:0]            word_t;
  typedef logic [$clog2(`FU_NUM_ROB)-1:0] rob_idx_t;
  typedef logic [$clog2(`FU_NUM_FL)-1:0]  fl_idx_t;
  typedef logic [$clog2(`FU_NUM_PR)-1:0]  pr_idx_t;
  typedef logic [4:0]                     arch_reg_t;
  typedef logic [7:0]                     lit_t;
  // branch displacement, counted in instruction words
  typedef logic [20:0]                    br_disp_t;

  // branch units only use ADDQ and AND
  typedef enum logic [3:0] {
    ALU_ADDQ, ALU_SUBQ,
    ALU_AND, ALU_BIC, ALU_BIS, ALU_ORNOT, ALU_XOR, ALU_EQV,
    ALU_SRL, ALU_SLL, ALU_SRA,
    ALU_CMPULT, ALU_CMPEQ, ALU_CMPULE, ALU_CMPLT, ALU_CMPLE
  } alu_func_e;

  typedef enum logic {
    OPA_IS_NPC,
    OPA_IS_NOT3
  } opa_sel_e;

  typedef enum logic [1:0] {
    OPB_IS_REGB,
    OPB_IS_ALU_IMM,
    OPB_IS_BR_DISP
  } opb_sel_e;

  // top bit negates the base test in the low two bits
  typedef enum logic [2:0] {
    BR_LBC = 3'b000,
    BR_EQ  = 3'b001,
    BR_LT  = 3'b010,
    BR_LE  = 3'b011,
    BR_LBS = 3'b100,
    BR_NE  = 3'b101,
    BR_GE  = 3'b110,
    BR_GT  = 3'b111
  } br_cond_e;

  // one operation from a reservation station, operands already read
  typedef struct packed {
    logic      ready;
    alu_func_e func;
    opa_sel_e  opa_sel;
    opb_sel_e  opb_sel;
    lit_t      lit;
    br_disp_t  disp;
    br_cond_e  cond;
    logic      cond_branch;
    logic      uncond_branch;
    word_t     npc;
    word_t     t1_value;
    word_t     t2_value;
    arch_reg_t dest_idx;
    pr_idx_t   t_idx;
    rob_idx_t  rob_idx;
    fl_idx_t   fl_idx;
  } fu_issue_t;

  typedef struct packed {
    logic      done;
    word_t     result;
    arch_reg_t dest_idx;
    pr_idx_t   t_idx;
    rob_idx_t  rob_idx;
    fl_idx_t   fl_idx;
  } fu_result_t;

  typedef struct packed {
    logic     valid;
    rob_idx_t rob_idx;
    fl_idx_t  fl_idx;
    word_t    target;
  } rollback_t;

  // multiplier pipe record, res.result carries the partial product
  typedef struct packed {
    fu_result_t res;
    word_t      mplier;
    word_t      mcand;
  } mult_stage_t;

  // tag at or after the rollback point, up to the tail, gets squashed
  // differences wrap modulo the ROB size through the index width
  function automatic logic is_squashed(rollback_t rb, rob_idx_t tag, rob_idx_t tail);
    rob_idx_t dist_tag;
    rob_idx_t dist_tail;
    dist_tag  = tag - rb.rob_idx;
    dist_tail = tail - rb.rob_idx;
    return rb.valid && (dist_tag <= dist_tail);
  endfunction

endpackage

`default_nettype wire

// File: exec_cluster_config.svh
`ifndef EXEC_CLUSTER_CONFIG_SVH
`define EXEC_CLUSTER_CONFIG_SVH

// datapath width in bits
`define FU_XLEN 64

// reorder buffer entries, power of two so tag arithmetic wraps
`define FU_NUM_ROB 32

// free list entries
`define FU_NUM_FL 32

// physical register file size
`define FU_NUM_PR 64

// multiplier pipeline depth
// must divide FU_XLEN (2, 4 and 8 all work)
`define FU_MULT_STAGES 4

`endif
